//--- verilog/rv_pkg.sv
package rv_pkg;

    // data and register number widths.
    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;

    // rv32i major opcodes, instr[6:0].
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_t;

    // operations the alu knows.
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_pass_b = 4'd6
    } alu_op_t;

    // where an execute operand comes from.
    // none is the value read in decode, mem and writeback are later stages.
    typedef enum logic [1:0] {
        none      = 2'b00,
        mem       = 2'b01,
        writeback = 2'b10
    } forward_type;

    // funct3 codes used by the alu decode.
    localparam logic [2:0] funct3_add = 3'b000;
    localparam logic [2:0] funct3_slt = 3'b010;
    localparam logic [2:0] funct3_xor = 3'b100;
    localparam logic [2:0] funct3_or  = 3'b110;
    localparam logic [2:0] funct3_and = 3'b111;
    localparam logic [2:0] funct3_w   = 3'b010;

endpackage

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  alu_op_t         op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result
);
    logic less;

    // signed compare for slt and slti.
    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, less};
            end
            alu_pass_b: begin
                result = b;
            end
            default: result = a + b;
        endcase
    end

endmodule

//--- verilog/decoder.sv
`timescale 1ns/1ps

module decoder import rv_pkg::*; (
    input  logic [31:0]               instr,
    output opcode_t                   opcode,
    output logic [reg_addr_width-1:0] rs1,
    output logic [reg_addr_width-1:0] rs2,
    output logic [reg_addr_width-1:0] rd,
    output logic [xlen-1:0]           imm,
    output alu_op_t                   alu_op,
    output logic                      use_imm,
    output logic                      use_pc,
    output logic                      reg_write,
    output logic                      mem_read,
    output logic                      mem_write
);
    logic [2:0] funct3;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    always_comb begin
        imm       = '0;
        alu_op    = alu_add;
        use_imm   = 1'b0;
        use_pc    = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        case (opcode)
            op_lui, op_auipc: begin
                imm       = {instr[31:12], 12'b0};
                alu_op    = (opcode == op_lui) ? alu_pass_b : alu_add;
                use_imm   = 1'b1;
                use_pc    = (opcode == op_auipc);
                reg_write = 1'b1;
            end
            op_imm, op_reg: begin
                imm       = {{20{instr[31]}}, instr[31:20]};
                use_imm   = (opcode == op_imm);
                reg_write = 1'b1;
                case (funct3)
                    // funct7 bit 5 picks sub, register form only.
                    funct3_add: alu_op = (opcode == op_reg && instr[30]) ? alu_sub : alu_add;
                    funct3_slt: alu_op = alu_slt;
                    funct3_xor: alu_op = alu_xor;
                    funct3_or:  alu_op = alu_or;
                    funct3_and: alu_op = alu_and;
                    default:    reg_write = 1'b0;
                endcase
            end
            op_load: begin
                imm       = {{20{instr[31]}}, instr[31:20]};
                use_imm   = 1'b1;
                reg_write = (funct3 == funct3_w);
                mem_read  = (funct3 == funct3_w);
            end
            op_store: begin
                imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                use_imm   = 1'b1;
                mem_write = (funct3 == funct3_w);
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/regfile.sv
`timescale 1ns/1ps

module regfile import rv_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [reg_addr_width-1:0] rs1,
    input  logic [reg_addr_width-1:0] rs2,
    input  logic                      we,
    input  logic [reg_addr_width-1:0] rd,
    input  logic [xlen-1:0]           wdata,
    output logic [xlen-1:0]           rdata1,
    output logic [xlen-1:0]           rdata2
);
    logic [xlen-1:0] regs [32];
    logic            write_live;

    // x0 is never written, so it always reads zero.
    assign write_live = we && (rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_live) begin
            regs[rd] <= wdata;
        end
    end

    // same-cycle write shows through to the reader.
    assign rdata1 = (write_live && rd == rs1) ? wdata : regs[rs1];
    assign rdata2 = (write_live && rd == rs2) ? wdata : regs[rs2];

endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import rv_pkg::*; (
    // registers read by the instruction in execute.
    input  logic [reg_addr_width-1:0] ex_reg_a,
    input  logic [reg_addr_width-1:0] ex_reg_b,
    input  opcode_t                   ex_opcode,
    // destination held in the memory stage.
    input  logic                      mem_reg_write_enable,
    input  logic [reg_addr_width-1:0] mem_reg_write_addr,
    input  opcode_t                   mem_opcode,
    // destination held in the writeback stage.
    input  logic                      wb_reg_write_enable,
    input  logic [reg_addr_width-1:0] wb_reg_write_addr,
    input  opcode_t                   wb_opcode,
    output forward_type               fwd_a,
    output forward_type               fwd_b,
    output logic                      pc_en,
    output logic                      front_en
);
    logic ex_a_used;
    logic ex_b_used;
    logic mem_dest_real;
    logic wb_dest_real;
    logic mem_hit_a;
    logic mem_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;
    logic load_use;

    // upper immediates and jal have no rs1 field.
    assign ex_a_used = !(ex_opcode inside {op_lui, op_auipc, op_jal});
    // only register ops, stores and branches read rs2.
    assign ex_b_used = !(ex_opcode inside {op_lui, op_auipc, op_jal, op_jalr, op_load, op_imm});
    // stores and branches have no rd.
    assign mem_dest_real = !(mem_opcode inside {op_store, op_branch});
    assign wb_dest_real  = !(wb_opcode inside {op_store, op_branch});

    assign mem_hit_a = mem_reg_write_enable && mem_dest_real && (mem_reg_write_addr != '0)
                       && (mem_reg_write_addr == ex_reg_a) && ex_a_used;
    assign mem_hit_b = mem_reg_write_enable && mem_dest_real && (mem_reg_write_addr != '0)
                       && (mem_reg_write_addr == ex_reg_b) && ex_b_used;
    assign wb_hit_a  = wb_reg_write_enable && wb_dest_real && (wb_reg_write_addr != '0)
                       && (wb_reg_write_addr == ex_reg_a) && ex_a_used;
    assign wb_hit_b  = wb_reg_write_enable && wb_dest_real && (wb_reg_write_addr != '0)
                       && (wb_reg_write_addr == ex_reg_b) && ex_b_used;

    // load data is not ready until writeback, so hold the front one cycle.
    assign load_use = (mem_opcode == op_load) && (mem_hit_a || mem_hit_b);
    assign pc_en    = !load_use;
    assign front_en = !load_use;

    // youngest producer wins.
    assign fwd_a = mem_hit_a ? mem : (wb_hit_a ? writeback : none);
    assign fwd_b = mem_hit_b ? mem : (wb_hit_b ? writeback : none);

endmodule

//--- verilog/pipeline_core.sv
`timescale 1ns/1ps

module pipeline_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    output logic [xlen-1:0] instr_addr,
    input  logic [xlen-1:0] instr_data,
    output logic [xlen-1:0] dmem_addr,
    output logic [xlen-1:0] dmem_wdata,
    output logic            dmem_we,
    input  logic [xlen-1:0] dmem_rdata
);
    // opcode carried by an empty slot, not a load and not a store.
    localparam opcode_t bubble_opcode = opcode_t'(7'd0);

    logic [xlen-1:0] pc;

    // fetch/decode register.
    logic            id_valid;
    logic [xlen-1:0] id_pc;
    logic [31:0]     id_instr;

    opcode_t                   dec_opcode;
    logic [reg_addr_width-1:0] dec_rs1;
    logic [reg_addr_width-1:0] dec_rs2;
    logic [reg_addr_width-1:0] dec_rd;
    logic [xlen-1:0]           dec_imm;
    alu_op_t                   dec_alu_op;
    logic                      dec_use_imm;
    logic                      dec_use_pc;
    logic                      dec_reg_write;
    logic                      dec_mem_read;
    logic                      dec_mem_write;
    logic [xlen-1:0]           rf_rdata1;
    logic [xlen-1:0]           rf_rdata2;

    // decode/execute register.
    logic                      ex_valid;
    logic [xlen-1:0]           ex_pc;
    opcode_t                   ex_opcode;
    logic [reg_addr_width-1:0] ex_rs1;
    logic [reg_addr_width-1:0] ex_rs2;
    logic [reg_addr_width-1:0] ex_rd;
    logic [xlen-1:0]           ex_imm;
    alu_op_t                   ex_alu_op;
    logic                      ex_use_imm;
    logic                      ex_use_pc;
    logic                      ex_reg_write;
    logic                      ex_mem_read;
    logic                      ex_mem_write;
    logic [xlen-1:0]           ex_rdata1;
    logic [xlen-1:0]           ex_rdata2;

    forward_type     fwd_a;
    forward_type     fwd_b;
    logic            pc_en;
    logic            front_en;
    logic [xlen-1:0] ex_src_a;
    logic [xlen-1:0] ex_src_b;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;

    // execute/memory register.
    logic                      mem_valid;
    opcode_t                   mem_opcode;
    logic [reg_addr_width-1:0] mem_rd;
    logic                      mem_reg_write;
    logic                      mem_mem_read;
    logic                      mem_mem_write;
    logic [xlen-1:0]           mem_alu_result;
    logic [xlen-1:0]           mem_store_data;

    // memory/writeback register.
    logic                      wb_valid;
    opcode_t                   wb_opcode;
    logic [reg_addr_width-1:0] wb_rd;
    logic                      wb_reg_write;
    logic                      wb_mem_read;
    logic [xlen-1:0]           wb_alu_result;
    logic [xlen-1:0]           wb_load_data;
    logic [xlen-1:0]           wb_value;
    logic                      wb_we;

    // fetch.
    assign instr_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            id_valid <= 1'b0;
        end else if (pc_en) begin
            pc       <= pc + 32'd4;
            id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (front_en) begin
            id_pc    <= pc;
            id_instr <= instr_data;
        end
    end

    // decode.
    decoder decoder_inst (
        .instr     (id_instr),
        .opcode    (dec_opcode),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .rd        (dec_rd),
        .imm       (dec_imm),
        .alu_op    (dec_alu_op),
        .use_imm   (dec_use_imm),
        .use_pc    (dec_use_pc),
        .reg_write (dec_reg_write),
        .mem_read  (dec_mem_read),
        .mem_write (dec_mem_write)
    );

    regfile regfile_inst (
        .clk    (clk),
        .reset  (reset),
        .rs1    (dec_rs1),
        .rs2    (dec_rs2),
        .we     (wb_we),
        .rd     (wb_rd),
        .wdata  (wb_value),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid     <= 1'b0;
            ex_opcode    <= bubble_opcode;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end else if (front_en) begin
            ex_valid     <= id_valid;
            ex_opcode    <= id_valid ? dec_opcode : bubble_opcode;
            ex_reg_write <= id_valid && dec_reg_write;
            ex_mem_read  <= id_valid && dec_mem_read;
            ex_mem_write <= id_valid && dec_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (front_en) begin
            ex_pc      <= id_pc;
            ex_rs1     <= dec_rs1;
            ex_rs2     <= dec_rs2;
            ex_rd      <= dec_rd;
            ex_imm     <= dec_imm;
            ex_alu_op  <= dec_alu_op;
            ex_use_imm <= dec_use_imm;
            ex_use_pc  <= dec_use_pc;
            ex_rdata1  <= rf_rdata1;
            ex_rdata2  <= rf_rdata2;
        end else begin
            // a held instruction keeps what writeback forwards to it.
            ex_rdata1  <= ex_src_a;
            ex_rdata2  <= ex_src_b;
        end
    end

    // execute.
    hazard_unit hazard_unit_inst (
        .ex_reg_a             (ex_rs1),
        .ex_reg_b             (ex_rs2),
        .ex_opcode            (ex_opcode),
        .mem_reg_write_enable (mem_valid && mem_reg_write),
        .mem_reg_write_addr   (mem_rd),
        .mem_opcode           (mem_opcode),
        .wb_reg_write_enable  (wb_we),
        .wb_reg_write_addr    (wb_rd),
        .wb_opcode            (wb_opcode),
        .fwd_a                (fwd_a),
        .fwd_b                (fwd_b),
        .pc_en                (pc_en),
        .front_en             (front_en)
    );

    always_comb begin
        case (fwd_a)
            mem:       ex_src_a = mem_alu_result;
            writeback: ex_src_a = wb_value;
            default:   ex_src_a = ex_rdata1;
        endcase
        case (fwd_b)
            mem:       ex_src_b = mem_alu_result;
            writeback: ex_src_b = wb_value;
            default:   ex_src_b = ex_rdata2;
        endcase
    end

    assign alu_a = ex_use_pc ? ex_pc : ex_src_a;
    assign alu_b = ex_use_imm ? ex_imm : ex_src_b;

    alu alu_inst (
        .op     (ex_alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    // a stall turns this slot into a bubble.
    always_ff @(posedge clk) begin
        if (reset || !front_en) begin
            mem_valid     <= 1'b0;
            mem_opcode    <= bubble_opcode;
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
        end else begin
            mem_valid     <= ex_valid;
            mem_opcode    <= ex_opcode;
            mem_reg_write <= ex_reg_write;
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
        end
    end

    // store data follows the forwarded rs2.
    always_ff @(posedge clk) begin
        mem_rd         <= ex_rd;
        mem_alu_result <= alu_result;
        mem_store_data <= ex_src_b;
    end

    // memory.
    assign dmem_addr  = mem_alu_result;
    assign dmem_wdata = mem_store_data;
    assign dmem_we    = mem_valid && mem_mem_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid     <= 1'b0;
            wb_opcode    <= bubble_opcode;
            wb_reg_write <= 1'b0;
            wb_mem_read  <= 1'b0;
        end else begin
            wb_valid     <= mem_valid;
            wb_opcode    <= mem_opcode;
            wb_reg_write <= mem_reg_write;
            wb_mem_read  <= mem_mem_read;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd         <= mem_rd;
        wb_alu_result <= mem_alu_result;
        wb_load_data  <= dmem_rdata;
    end

    // writeback.
    assign wb_value = wb_mem_read ? wb_load_data : wb_alu_result;
    assign wb_we    = wb_valid && wb_reg_write;

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);
    // 100 ns period, low for the first half.
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

endmodule

//--- verif/tb_pipeline_core.sv
`timescale 1ns/1ps

module tb_pipeline_core;
    localparam logic [6:0]  opc_lui   = 7'b0110111;
    localparam logic [6:0]  opc_auipc = 7'b0010111;
    localparam logic [6:0]  opc_load  = 7'b0000011;
    localparam logic [6:0]  opc_store = 7'b0100011;
    localparam logic [6:0]  opc_imm   = 7'b0010011;
    localparam logic [6:0]  opc_reg   = 7'b0110011;
    localparam logic [31:0] nop       = 32'h00000013;

    logic        clk;
    logic        reset;
    logic [31:0] instr_addr;
    logic [31:0] instr_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] init_image [64];
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    integer      seed;
    string       test_name;
    int          store_index;
    int          check_errors;
    int          pass_count;
    int          fail_count;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    tb_clock_gen clock_gen_inst (
        .clk (clk)
    );

    pipeline_core pipeline_core_inst (
        .clk        (clk),
        .reset      (reset),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    // both memories answer in the same cycle, quiet while the core is in reset.
    assign instr_data = reset ? nop
                      : ((instr_addr[31:8] == '0) ? imem[instr_addr[7:2]] : nop);
    assign dmem_rdata = reset ? '0 : dmem[dmem_addr[7:2]];

    // data memory takes its start image during reset.
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= init_image[i];
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    // every store is matched against the next one the model expects.
    always @(posedge clk) begin : store_check
        int bad;
        bad = 0;
        if (reset) begin
            store_index  <= 0;
            check_errors <= 0;
        end else if (dmem_we) begin
            assert (store_index < exp_addr.size()) else begin
                $display("%s: extra store to address %h, program has no store left",
                         test_name, dmem_addr);
                bad++;
            end
            if (store_index < exp_addr.size()) begin
                assert (dmem_addr == exp_addr[store_index]) else begin
                    $display("ERROR %s: store %0d address expected %h actual %h",
                             test_name, store_index, exp_addr[store_index], dmem_addr);
                    bad++;
                end
                assert (dmem_wdata == exp_data[store_index]) else begin
                    $display("ERROR %s: store %0d data expected %h actual %h",
                             test_name, store_index, exp_data[store_index], dmem_wdata);
                    bad++;
                end
            end
            store_index  <= store_index + 1;
            check_errors <= check_errors + bad;
        end
    end

    // run limit grows with each program that starts.
    always @(negedge clk) begin
        if (!reset) begin
            cycle_count <= cycle_count + 1;
        end
        if (cycle_count > cycle_limit) begin
            $display("timeout: core still running after %0d cycles", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [11:0] rand_imm();
        logic [31:0] w;
        w = rand_word();
        return w[11:0];
    endfunction

    // word offset inside the 64-word data memory.
    function automatic logic [11:0] rand_offset();
        logic [31:0] w;
        w = rand_word();
        return {4'b0000, w[5:0], 2'b00};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] r_type(input logic sub, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {1'b0, sub, 5'b00000, rs2, rs1, f3, rd, opc_reg};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return i_type(opc_imm, rd, 3'b000, rs1, imm);
    endfunction

    function automatic logic [31:0] add_r(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return r_type(1'b0, 3'b000, rd, rs1, rs2);
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [11:0] imm);
        return i_type(opc_load, rd, 3'b010, 5'd0, imm);
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], opc_store};
    endfunction

    // architectural model, one instruction at a time with no pipeline.
    function automatic void run_reference();
        logic [31:0] regs [32];
        logic [31:0] data [64];
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] res;
        logic        wr;
        exp_addr = {};
        exp_data = {};
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int w = 0; w < 64; w++) begin
            data[w] = init_image[w];
        end
        for (int i = 0; i < prog.size(); i++) begin
            ins   = prog[i];
            a     = regs[ins[19:15]];
            b     = regs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            res   = '0;
            wr    = 1'b1;
            case (ins[6:0])
                opc_lui:   res = {ins[31:12], 12'h000};
                opc_auipc: res = 32'(i * 4) + {ins[31:12], 12'h000};
                opc_load: begin
                    addr = a + imm_i;
                    res  = data[addr[7:2]];
                end
                opc_store: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    data[addr[7:2]] = b;
                    wr = 1'b0;
                end
                opc_imm, opc_reg: begin
                    if (ins[6:0] == opc_imm) begin
                        b = imm_i;
                    end
                    case (ins[14:12])
                        3'b000:  res = (ins[6:0] == opc_reg && ins[30]) ? a - b : a + b;
                        3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        3'b111:  res = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                default: wr = 1'b0;
            endcase
            // x0 stays zero.
            if (wr && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = res;
            end
        end
    endfunction

    task automatic build_alu_chain();
        prog = {};
        prog.push_back(addi(5'd1, 5'd0, rand_imm()));
        prog.push_back(addi(5'd2, 5'd1, rand_imm()));
        prog.push_back(add_r(5'd3, 5'd2, 5'd1));
        prog.push_back(r_type(1'b1, 3'b000, 5'd4, 5'd3, 5'd2));
        prog.push_back(i_type(opc_imm, 5'd5, 3'b100, 5'd4, rand_imm()));
        prog.push_back(r_type(1'b0, 3'b110, 5'd6, 5'd5, 5'd4));
        prog.push_back(r_type(1'b0, 3'b111, 5'd7, 5'd6, 5'd3));
        prog.push_back(r_type(1'b0, 3'b010, 5'd8, 5'd7, 5'd5));
        prog.push_back(i_type(opc_imm, 5'd9, 3'b010, 5'd8, rand_imm()));
        prog.push_back(sw(5'd4, rand_offset()));
        prog.push_back(sw(5'd7, rand_offset()));
        prog.push_back(sw(5'd9, rand_offset()));
    endtask

    // one, then two, independent instructions between producer and consumer.
    task automatic build_wb_forward();
        prog = {};
        prog.push_back(addi(5'd1, 5'd0, rand_imm()));
        prog.push_back(addi(5'd10, 5'd0, rand_imm()));
        prog.push_back(add_r(5'd2, 5'd1, 5'd1));
        prog.push_back(addi(5'd3, 5'd0, rand_imm()));
        prog.push_back(addi(5'd11, 5'd0, rand_imm()));
        prog.push_back(addi(5'd12, 5'd0, rand_imm()));
        prog.push_back(add_r(5'd4, 5'd3, 5'd2));
        prog.push_back(sw(5'd2, rand_offset()));
        prog.push_back(sw(5'd4, rand_offset()));
    endtask

    task automatic build_load_use();
        prog = {};
        prog.push_back(addi(5'd3, 5'd0, rand_imm()));
        prog.push_back(lw(5'd1, rand_offset()));
        prog.push_back(add_r(5'd2, 5'd1, 5'd3));
        prog.push_back(sw(5'd2, rand_offset()));
        prog.push_back(lw(5'd4, rand_offset()));
        prog.push_back(sw(5'd4, rand_offset()));
        prog.push_back(lw(5'd5, rand_offset()));
        prog.push_back(add_r(5'd6, 5'd3, 5'd5));
        prog.push_back(sw(5'd6, rand_offset()));
    endtask

    task automatic build_operand_valid();
        logic [31:0] w;
        prog = {};
        w = rand_word();
        prog.push_back(u_type(opc_lui, 5'd1, w[19:0]));
        w = rand_word();
        prog.push_back(u_type(opc_auipc, 5'd2, w[31:12]));
        prog.push_back(sw(5'd1, rand_offset()));
        prog.push_back(sw(5'd2, rand_offset()));
        prog.push_back(addi(5'd0, 5'd1, rand_imm()));
        prog.push_back(sw(5'd0, rand_offset()));
        prog.push_back(add_r(5'd3, 5'd0, 5'd1));
        prog.push_back(sw(5'd3, rand_offset()));
        // the immediate's low bits name x5 in the unused rs2 field.
        prog.push_back(lw(5'd5, rand_offset()));
        prog.push_back(addi(5'd6, 5'd1, {7'h2a, 5'd5}));
        prog.push_back(sw(5'd6, rand_offset()));
    endtask

    task automatic build_store_order();
        prog = {};
        prog.push_back(addi(5'd1, 5'd0, rand_imm()));
        prog.push_back(sw(5'd1, rand_offset()));
        prog.push_back(addi(5'd2, 5'd1, rand_imm()));
        for (int k = 0; k < 4; k++) begin
            prog.push_back(sw(5'd2, rand_offset()));
            prog.push_back(sw(5'd1, rand_offset()));
            prog.push_back(addi(5'd2, 5'd2, rand_imm()));
        end
        prog.push_back(sw(5'd2, rand_offset()));
    endtask

    task automatic run_test(input string name);
        int budget;
        bit missing;
        bit reset_bad;
        @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        test_name = name;
        for (int i = 0; i < 64; i++) begin
            if (i < prog.size()) begin
                imem[i] = prog[i];
            end else begin
                imem[i] = nop;
            end
            init_image[i] = rand_word();
        end
        run_reference();
        budget      = 2 * prog.size() + 20;
        cycle_limit = cycle_limit + budget;
        repeat (4) @(posedge clk);
        reset_bad = 1'b0;
        assert (instr_addr == 32'd0) else begin
            $display("ERROR %s: pc after reset expected %h actual %h",
                     name, 32'd0, instr_addr);
            reset_bad = 1'b1;
        end
        reset <= 1'b0;
        // done once the last instruction has drained past writeback.
        do begin
            @(negedge clk);
        end while (instr_addr < 32'(4 * prog.size() + 16));
        missing = 1'b0;
        assert (store_index >= exp_addr.size()) else begin
            $display("%s: only %0d of %0d expected stores appeared",
                     name, store_index, exp_addr.size());
            missing = 1'b1;
        end
        if (check_errors == 0 && !missing && !reset_bad) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: FAIL", name);
        end
    endtask

    initial begin
        reset      = 1'b1;
        seed       = 32'hdc16;
        pass_count = 0;
        fail_count = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i]       = nop;
            init_image[i] = '0;
        end
        build_alu_chain();
        run_test("alu_chain");
        build_wb_forward();
        run_test("wb_forward");
        build_load_use();
        run_test("load_use");
        build_operand_valid();
        run_test("operand_valid");
        build_store_order();
        run_test("store_order");
        $display("summary: %0d passed, %0d failing", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- pipeline_core.f
verilog/rv_pkg.sv
verilog/alu.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/hazard_unit.sv
verilog/pipeline_core.sv
verif/tb_clock_gen.sv
verif/tb_pipeline_core.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_pipeline_core -f pipeline_core.f \
    && ./obj_dir/Vtb_pipeline_core | tee /dev/stderr | grep -x "all tests passed" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
